/* verilog.f */
rtl/buf_cfg_pkg.sv
rtl/buf_op_pkg.sv
rtl/page_cmd_decoder.sv
rtl/free_page_fifo.sv
rtl/page_accounting.sv
rtl/page_link_table.sv
rtl/page_state_top.sv
tests/tb_clock_gen.sv
tests/page_state_tb.sv

/* tests/page_state_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module page_state_tb;

    localparam int max_rows   = 2200;
    localparam int tbl_checks = 16;

    typedef logic [buf_cfg_pkg::port_w-1:0]      port_t;
    typedef logic [buf_cfg_pkg::count_w-1:0]     count_t;
    typedef logic [buf_cfg_pkg::page_addr_w-1:0] addr_t;
    typedef logic [buf_cfg_pkg::link_w-1:0]      word_t;

    // one stimulus row and the state expected after it.
    typedef struct packed {
        buf_op_pkg::buf_req_t req;
        port_t                qp;
        count_t               free;
        count_t               amount;
        addr_t                head;
    } row_t;

    wire                              clk;
    wire                              rst_n;
    buf_op_pkg::buf_req_t             req;
    buf_op_pkg::tbl_wr_t              jt_wr;
    buf_op_pkg::tbl_wr_t              ecc_wr;
    logic                             jt_rd_en;
    addr_t                            jt_rd_addr;
    logic                             ecc_rd_en;
    addr_t                            ecc_rd_addr;
    port_t                            query_port;
    wire                              ready;
    wire addr_t                       null_ptr;
    wire count_t                      free_space;
    wire count_t                      page_amount;
    wire word_t                       jt_dout;
    wire [buf_cfg_pkg::ecc_w-1:0]     ecc_dout;

    row_t   rows  [max_rows];
    string  names [max_rows];
    int     n_rows;

    // reference model of the free queue and the counters.
    addr_t  free_q [$];
    count_t free_model;
    count_t port_model [buf_cfg_pkg::port_count];

    integer seed = 32'hb0754d2a;
    int     value_errors;
    int     other_errors;
    int     cycle_count;
    int     cycle_limit;

    tb_clock_gen u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    page_state_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .jt_wr       (jt_wr),
        .ecc_wr      (ecc_wr),
        .jt_rd_en    (jt_rd_en),
        .jt_rd_addr  (jt_rd_addr),
        .ecc_rd_en   (ecc_rd_en),
        .ecc_rd_addr (ecc_rd_addr),
        .query_port  (query_port),
        .ready       (ready),
        .null_ptr    (null_ptr),
        .free_space  (free_space),
        .page_amount (page_amount),
        .jt_dout     (jt_dout),
        .ecc_dout    (ecc_dout)
    );

    task automatic compare_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic verify_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic match_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: expected 0x%04h, actual 0x%04h", name, exp, act);
        end
    endtask

    function automatic buf_op_pkg::buf_req_t pack_req(
        input logic wr_op, input logic pop, input int wr_port, input int delta_free,
        input int delta_pages, input logic rd_op, input int rd_port, input int rd_page);
        buf_op_pkg::buf_req_t r;
        r.wr_op       = wr_op;
        r.pop         = pop;
        r.wr_port     = port_t'(wr_port);
        r.delta_free  = count_t'(delta_free);
        r.delta_pages = count_t'(delta_pages);
        r.rd_op       = rd_op;
        r.rd_port     = port_t'(rd_port);
        r.rd_page     = addr_t'(rd_page);
        return r;
    endfunction

    task automatic add_row(input string name, input buf_op_pkg::buf_req_t r, input int qp);
        row_t row;
        if (r.wr_op && !r.rd_op) begin
            free_model = free_model - r.delta_free;
            port_model[r.wr_port] = port_model[r.wr_port] + r.delta_pages;
        end else if (!r.wr_op && r.rd_op) begin
            free_model = free_model + count_t'(1);
            port_model[r.rd_port] = port_model[r.rd_port] - count_t'(1);
        end else if (r.wr_op && r.rd_op && (r.wr_port != r.rd_port)) begin
            port_model[r.wr_port] = port_model[r.wr_port] + count_t'(1);
            port_model[r.rd_port] = port_model[r.rd_port] - count_t'(1);
        end
        if (r.pop) begin
            free_q.delete(0);
        end
        if (r.rd_op) begin
            free_q.push_back(r.rd_page);
        end
        row.req    = r;
        row.qp     = port_t'(qp);
        row.free   = free_model;
        row.amount = port_model[qp];
        row.head   = free_q[0];
        rows[n_rows]  = row;
        names[n_rows] = name;
        n_rows++;
    endtask

    task automatic build_table();
        int bulk;
        free_q.delete();
        for (int p = 0; p < buf_cfg_pkg::page_count; p++) begin
            free_q.push_back(addr_t'(p));
        end
        free_model = count_t'(buf_cfg_pkg::page_count);
        for (int p = 0; p < buf_cfg_pkg::port_count; p++) begin
            port_model[p] = '0;
        end
        n_rows = 0;
        for (int i = 0; i < 8; i++) begin
            add_row("alloc", pack_req(1'b1, 1'b1, (i * 3) % 16, 1 + i % 3, 1 + i % 3,
                                      1'b0, 0, 0), (i * 3) % 16);
        end
        // pages come back out of order.
        add_row("release", pack_req(1'b0, 1'b0, 0, 0, 0, 1'b1, 3, 6), 3);
        add_row("release", pack_req(1'b0, 1'b0, 0, 0, 0, 1'b1, 6, 2), 6);
        add_row("release", pack_req(1'b0, 1'b0, 0, 0, 0, 1'b1, 9, 7), 9);
        add_row("release", pack_req(1'b0, 1'b0, 0, 0, 0, 1'b1, 12, 4), 12);
        // drain until one released page is left.
        bulk = free_q.size() - 1;
        for (int i = 0; i < bulk; i++) begin
            add_row("drain", pack_req(1'b1, 1'b1, 15, 0, 0, 1'b0, 0, 0), i % 16);
        end
        // with one page queued, the pushed page is the next head.
        add_row("transfer", pack_req(1'b1, 1'b1, 0, 0, 0, 1'b1, 15, 100), 15);
        add_row("transfer", pack_req(1'b1, 1'b1, 2, 0, 0, 1'b1, 5, 200), 2);
        add_row("transfer same port", pack_req(1'b1, 1'b1, 12, 0, 0, 1'b1, 12, 300), 12);
        add_row("transfer same port", pack_req(1'b1, 1'b1, 9, 0, 0, 1'b1, 9, 400), 9);
        add_row("transfer", pack_req(1'b1, 1'b1, 5, 0, 0, 1'b1, 0, 500), 0);
    endtask

    // a write with pop while the queue fills must be dropped.
    task automatic fill_probe();
        repeat (4) begin
            @(posedge clk);
            req <= pack_req(1'b1, 1'b1, 4, 7, 7, 1'b0, 0, 0);
        end
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        if (ready !== 1'b0) begin
            other_errors++;
            $display("ready was high while the free queue was still filling");
        end
        match_word("jt_dout during fill", '0, jt_dout);
        match_word("ecc_dout during fill", '0, word_t'(ecc_dout));
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while ((ready !== 1'b1) && (n < buf_cfg_pkg::page_count + 16)) begin
            @(negedge clk);
            n++;
        end
        if (ready !== 1'b1) begin
            other_errors++;
            $display("ready did not rise within %0d cycles after reset", n);
        end
    endtask

    task automatic idle_scan();
        compare_count("free_space after fill", count_t'(buf_cfg_pkg::page_count), free_space);
        verify_addr("null_ptr after fill", '0, null_ptr);
        for (int p = 0; p < buf_cfg_pkg::port_count; p++) begin
            @(posedge clk);
            query_port <= port_t'(p);
            @(negedge clk);
            compare_count($sformatf("page_amount port %0d after fill", p), '0, page_amount);
        end
    endtask

    // row i is driven at edge i and checked after edge i+2.
    task automatic run_rows();
        for (int i = 0; i < n_rows + 2; i++) begin
            @(posedge clk);
            if (i < n_rows) begin
                req <= rows[i].req;
            end else begin
                req <= '0;
            end
            if (i >= 2) begin
                query_port <= rows[i-2].qp;
            end
            @(negedge clk);
            if (i >= 2) begin
                compare_count({names[i-2], " free_space"}, rows[i-2].free, free_space);
                compare_count({names[i-2], " page_amount"}, rows[i-2].amount, page_amount);
                verify_addr({names[i-2], " null_ptr"}, rows[i-2].head, null_ptr);
            end
        end
    endtask

    task automatic exercise_tables();
        buf_op_pkg::tbl_wr_t w;
        logic [31:0]         rnd;
        addr_t               jt_addr;
        addr_t               ecc_addr;
        word_t               jt_data;
        word_t               ecc_data;
        for (int k = 0; k < tbl_checks; k++) begin
            rnd      = $random(seed);
            jt_addr  = rnd[10:0];
            ecc_addr = rnd[26:16];
            rnd      = $random(seed);
            jt_data  = rnd[15:0];
            ecc_data = rnd[31:16];
            @(posedge clk);
            w.en    = 1'b1;
            w.addr  = jt_addr;
            w.data  = jt_data;
            jt_wr  <= w;
            w.addr  = ecc_addr;
            w.data  = ecc_data;
            ecc_wr <= w;
            @(posedge clk);
            jt_wr       <= '0;
            ecc_wr      <= '0;
            jt_rd_en    <= 1'b1;
            jt_rd_addr  <= jt_addr;
            ecc_rd_en   <= 1'b1;
            ecc_rd_addr <= ecc_addr;
            @(posedge clk);
            jt_rd_en  <= 1'b0;
            ecc_rd_en <= 1'b0;
            @(negedge clk);
            match_word($sformatf("jt read page %0d", jt_addr), jt_data, jt_dout);
            // ecc entries keep the low byte only.
            match_word($sformatf("ecc read page %0d", ecc_addr),
                       word_t'(ecc_data[buf_cfg_pkg::ecc_w-1:0]), word_t'(ecc_dout));
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if ((cycle_limit != 0) && (cycle_count > cycle_limit)) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        req          = '0;
        jt_wr        = '0;
        ecc_wr       = '0;
        jt_rd_en     = 1'b0;
        jt_rd_addr   = '0;
        ecc_rd_en    = 1'b0;
        ecc_rd_addr  = '0;
        query_port   = '0;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        build_table();
        cycle_limit = 10 + buf_cfg_pkg::page_count + 4 * n_rows + 4 * tbl_checks + 100;
        wait (rst_n === 1'b1);
        fill_probe();
        wait_ready();
        if (ready === 1'b1) begin
            idle_scan();
            run_rows();
            exercise_tables();
        end
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int reset_cycles = 10;

    // 100 ns period.
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/page_state_top.sv */
`timescale 1ns/1ps
`default_nettype none

module page_state_top (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire buf_op_pkg::buf_req_t           req,
    input  wire buf_op_pkg::tbl_wr_t            jt_wr,
    input  wire buf_op_pkg::tbl_wr_t            ecc_wr,
    input  wire                                 jt_rd_en,
    input  wire [buf_cfg_pkg::page_addr_w-1:0]  jt_rd_addr,
    input  wire                                 ecc_rd_en,
    input  wire [buf_cfg_pkg::page_addr_w-1:0]  ecc_rd_addr,
    input  wire [buf_cfg_pkg::port_w-1:0]       query_port,
    output wire                                 ready,
    output wire [buf_cfg_pkg::page_addr_w-1:0]  null_ptr,
    output wire [buf_cfg_pkg::count_w-1:0]      free_space,
    output wire [buf_cfg_pkg::count_w-1:0]      page_amount,
    output wire [buf_cfg_pkg::link_w-1:0]       jt_dout,
    output wire [buf_cfg_pkg::ecc_w-1:0]        ecc_dout
);

    // decoded command, shared by the queue and the counters.
    buf_op_pkg::buf_cmd_t cmd;

    page_cmd_decoder u_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .ready (ready),
        .cmd   (cmd)
    );

    free_page_fifo u_free_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .ready    (ready),
        .null_ptr (null_ptr)
    );

    page_accounting u_accounting (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .query_port  (query_port),
        .free_space  (free_space),
        .page_amount (page_amount)
    );

    page_link_table u_tables (
        .clk         (clk),
        .rst_n       (rst_n),
        .jt_wr       (jt_wr),
        .jt_rd_en    (jt_rd_en),
        .jt_rd_addr  (jt_rd_addr),
        .ecc_wr      (ecc_wr),
        .ecc_rd_en   (ecc_rd_en),
        .ecc_rd_addr (ecc_rd_addr),
        .jt_dout     (jt_dout),
        .ecc_dout    (ecc_dout)
    );

endmodule

`default_nettype wire

/* rtl/page_link_table.sv */
`timescale 1ns/1ps
`default_nettype none

module page_link_table (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire buf_op_pkg::tbl_wr_t            jt_wr,
    input  wire                                 jt_rd_en,
    input  wire [buf_cfg_pkg::page_addr_w-1:0]  jt_rd_addr,
    input  wire buf_op_pkg::tbl_wr_t            ecc_wr,
    input  wire                                 ecc_rd_en,
    input  wire [buf_cfg_pkg::page_addr_w-1:0]  ecc_rd_addr,
    output logic [buf_cfg_pkg::link_w-1:0]      jt_dout,
    output logic [buf_cfg_pkg::ecc_w-1:0]       ecc_dout
);

    // next-page links of each packet.
    logic [buf_cfg_pkg::link_w-1:0] jt_mem  [buf_cfg_pkg::page_count];
    // one check byte per page.
    logic [buf_cfg_pkg::ecc_w-1:0]  ecc_mem [buf_cfg_pkg::page_count];

    always_ff @(posedge clk) begin
        if (rst_n && jt_wr.en) begin
            jt_mem[jt_wr.addr] <= jt_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            jt_dout <= '0;
        end else if (jt_rd_en) begin
            jt_dout <= jt_mem[jt_rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n && ecc_wr.en) begin
            ecc_mem[ecc_wr.addr] <= ecc_wr.data[buf_cfg_pkg::ecc_w-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ecc_dout <= '0;
        end else if (ecc_rd_en) begin
            ecc_dout <= ecc_mem[ecc_rd_addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/page_accounting.sv */
`timescale 1ns/1ps
`default_nettype none

module page_accounting (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire buf_op_pkg::buf_cmd_t           cmd,
    input  wire [buf_cfg_pkg::port_w-1:0]       query_port,
    output logic [buf_cfg_pkg::count_w-1:0]     free_space,
    output logic [buf_cfg_pkg::count_w-1:0]     page_amount
);

    logic [buf_cfg_pkg::port_count-1:0][buf_cfg_pkg::count_w-1:0] port_cnt;
    logic                                                          rd_dec;

    assign page_amount = port_cnt[query_port];

    // read port loses a page, except a transfer within one port.
    assign rd_dec = (cmd.opcode == buf_op_pkg::op_release) ||
                    ((cmd.opcode == buf_op_pkg::op_transfer) &&
                     (cmd.wr_port != cmd.rd_port));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_space <= buf_cfg_pkg::count_full;
            port_cnt   <= '0;
        end else begin
            case (cmd.opcode)
                buf_op_pkg::op_alloc: begin
                    free_space <= free_space - cmd.delta_free;
                    port_cnt[cmd.wr_port] <= port_cnt[cmd.wr_port] + cmd.delta_pages;
                end
                buf_op_pkg::op_release: begin
                    free_space <= free_space + buf_cfg_pkg::count_one;
                    port_cnt[cmd.rd_port] <= port_cnt[cmd.rd_port] - buf_cfg_pkg::count_one;
                end
                buf_op_pkg::op_transfer: begin
                    // free space stays put.
                    if (cmd.wr_port != cmd.rd_port) begin
                        port_cnt[cmd.wr_port] <=
                            port_cnt[cmd.wr_port] + buf_cfg_pkg::count_one;
                        port_cnt[cmd.rd_port] <=
                            port_cnt[cmd.rd_port] - buf_cfg_pkg::count_one;
                    end
                end
                default: begin
                    free_space <= free_space;
                end
            endcase
        end
    end

    a_no_port_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        rd_dec |-> (port_cnt[cmd.rd_port] != '0));

    // Pages only move between the pool and the ports, so the pool can't exceed its size.
    a_free_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        free_space <= buf_cfg_pkg::count_full);

endmodule

`default_nettype wire

/* rtl/free_page_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module free_page_fifo (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire buf_op_pkg::buf_cmd_t           cmd,
    output logic                                ready,
    output logic [buf_cfg_pkg::page_addr_w-1:0] null_ptr
);

    logic [buf_cfg_pkg::page_addr_w-1:0] page_mem [buf_cfg_pkg::page_count];

    buf_op_pkg::fill_state_t             state;
    logic [buf_cfg_pkg::page_addr_w-1:0] fill_idx;
    logic [buf_cfg_pkg::page_addr_w-1:0] head;
    logic [buf_cfg_pkg::page_addr_w-1:0] tail;
    logic [buf_cfg_pkg::page_addr_w-1:0] head_nxt;
    logic [buf_cfg_pkg::page_addr_w-1:0] head_data;
    logic [buf_cfg_pkg::count_w-1:0]     used;
    logic                                pop;
    logic                                push;
    logic                                mem_we;
    logic [buf_cfg_pkg::page_addr_w-1:0] mem_waddr;
    logic [buf_cfg_pkg::page_addr_w-1:0] mem_wdata;

    assign ready = (state == buf_op_pkg::st_run);
    assign pop   = ready && cmd.pop;
    assign push  = ready && ((cmd.opcode == buf_op_pkg::op_release) ||
                             (cmd.opcode == buf_op_pkg::op_transfer));

    assign head_nxt = pop ? head + buf_cfg_pkg::addr_one : head;

    // one write port, shared by the fill and the released pages.
    always_comb begin
        if (state == buf_op_pkg::st_fill) begin
            mem_we    = rst_n;
            mem_waddr = fill_idx;
            mem_wdata = fill_idx;
        end else begin
            mem_we    = push;
            mem_waddr = tail;
            mem_wdata = cmd.rd_page;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= buf_op_pkg::st_fill;
            fill_idx <= '0;
            head     <= '0;
            tail     <= '0;
            used     <= '0;
        end else if (state == buf_op_pkg::st_fill) begin
            fill_idx <= fill_idx + buf_cfg_pkg::addr_one;
            if (fill_idx == buf_cfg_pkg::last_page) begin
                state <= buf_op_pkg::st_run;
                used  <= buf_cfg_pkg::count_full;
            end
        end else begin
            head <= head_nxt;
            if (push) begin
                tail <= tail + buf_cfg_pkg::addr_one;
            end
            case ({push, pop})
                2'b10:   used <= used + buf_cfg_pkg::count_one;
                2'b01:   used <= used - buf_cfg_pkg::count_one;
                default: used <= used;
            endcase
        end
    end

    // head word is read one entry ahead.
    // a write to that entry in the same cycle is forwarded.
    always_ff @(posedge clk) begin
        if (mem_we) begin
            page_mem[mem_waddr] <= mem_wdata;
        end
        if (mem_we && (mem_waddr == head_nxt)) begin
            head_data <= mem_wdata;
        end else begin
            head_data <= page_mem[head_nxt];
        end
    end

    assign null_ptr = head_data;

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (used != '0));

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        (push && !pop) |-> (used != buf_cfg_pkg::count_full));

endmodule

`default_nettype wire

/* rtl/page_cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module page_cmd_decoder (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire buf_op_pkg::buf_req_t req,
    input  wire                       ready,
    output buf_op_pkg::buf_cmd_t      cmd
);

    buf_op_pkg::buf_opcode_t             opcode_d;
    buf_op_pkg::buf_opcode_t             opcode_q;
    logic                                pop_q;
    logic [buf_cfg_pkg::port_w-1:0]      wr_port_q;
    logic [buf_cfg_pkg::count_w-1:0]     delta_free_q;
    logic [buf_cfg_pkg::count_w-1:0]     delta_pages_q;
    logic [buf_cfg_pkg::port_w-1:0]      rd_port_q;
    logic [buf_cfg_pkg::page_addr_w-1:0] rd_page_q;

    always_comb begin
        case ({req.wr_op, req.rd_op})
            2'b10:   opcode_d = buf_op_pkg::op_alloc;
            2'b01:   opcode_d = buf_op_pkg::op_release;
            2'b11:   opcode_d = buf_op_pkg::op_transfer;
            default: opcode_d = buf_op_pkg::op_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            opcode_q <= buf_op_pkg::op_idle;
            pop_q    <= 1'b0;
        end else if (!ready) begin
            // requests during the fill are dropped.
            opcode_q <= buf_op_pkg::op_idle;
            pop_q    <= 1'b0;
        end else begin
            opcode_q <= opcode_d;
            pop_q    <= req.pop;
        end
    end

    always_ff @(posedge clk) begin
        wr_port_q     <= req.wr_port;
        delta_free_q  <= req.delta_free;
        delta_pages_q <= req.delta_pages;
        rd_port_q     <= req.rd_port;
        rd_page_q     <= req.rd_page;
    end

    always_comb begin
        cmd.opcode      = opcode_q;
        cmd.pop         = pop_q;
        cmd.wr_port     = wr_port_q;
        cmd.delta_free  = delta_free_q;
        cmd.delta_pages = delta_pages_q;
        cmd.rd_port     = rd_port_q;
        cmd.rd_page     = rd_page_q;
    end

    // a page leaves the free queue only for a write.
    a_pop_with_write: assert property (@(posedge clk) disable iff (!rst_n)
        req.pop |-> req.wr_op);

endmodule

`default_nettype wire

/* rtl/buf_op_pkg.sv */
`default_nettype none

package buf_op_pkg;

    // what the counters and the free queue do with one request.
    typedef enum logic [1:0] {
        op_idle     = 2'd0,
        op_alloc    = 2'd1,
        op_release  = 2'd2,
        op_transfer = 2'd3
    } buf_opcode_t;

    typedef enum logic {
        st_fill = 1'b0,
        st_run  = 1'b1
    } fill_state_t;

    // plain strobes from the schedulers.
    typedef struct packed {
        logic                                wr_op;
        logic                                pop;
        logic [buf_cfg_pkg::port_w-1:0]      wr_port;
        logic [buf_cfg_pkg::count_w-1:0]     delta_free;
        logic [buf_cfg_pkg::count_w-1:0]     delta_pages;
        logic                                rd_op;
        logic [buf_cfg_pkg::port_w-1:0]      rd_port;
        logic [buf_cfg_pkg::page_addr_w-1:0] rd_page;
    } buf_req_t;

    typedef struct packed {
        buf_opcode_t                         opcode;
        logic                                pop;
        logic [buf_cfg_pkg::port_w-1:0]      wr_port;
        logic [buf_cfg_pkg::count_w-1:0]     delta_free;
        logic [buf_cfg_pkg::count_w-1:0]     delta_pages;
        logic [buf_cfg_pkg::port_w-1:0]      rd_port;
        logic [buf_cfg_pkg::page_addr_w-1:0] rd_page;
    } buf_cmd_t;

    // data is sized for the jump table, the ecc table uses the low bits.
    typedef struct packed {
        logic                                en;
        logic [buf_cfg_pkg::page_addr_w-1:0] addr;
        logic [buf_cfg_pkg::link_w-1:0]      data;
    } tbl_wr_t;

endpackage

`default_nettype wire

/* rtl/buf_cfg_pkg.sv */
`default_nettype none

package buf_cfg_pkg;

    // page storage.
    localparam int page_count  = 2048;
    localparam int page_addr_w = 11;

    // switch ports.
    localparam int port_count = 16;
    localparam int port_w     = 4;

    // free and per-port counters, wide enough to hold page_count.
    localparam int count_w = 12;

    // per-page tables.
    localparam int link_w = 16;
    localparam int ecc_w  = 8;

    // sized constants for the counters and pointers.
    localparam logic [count_w-1:0]     count_one  = count_w'(1);
    localparam logic [count_w-1:0]     count_full = count_w'(page_count);
    localparam logic [page_addr_w-1:0] addr_one   = page_addr_w'(1);
    localparam logic [page_addr_w-1:0] last_page  = page_addr_w'(page_count - 1);

endpackage

`default_nettype wire
